//--- byte_fifo.sv
// Byte FIFO with valid/ready streams and level-based rts flow control.

`default_nettype none

module byte_fifo #(
    parameter int unsigned FIFO_DEPTH = 8,
    parameter int unsigned RTS_MARGIN = 2
) (
    input  logic                   clk_i,
    input  logic                   arstn_i,
    input  byte_stream_pkg::byte_t s_data_i,
    input  logic                   s_valid_i,
    input  logic                   m_ready_i,
    output logic                   s_ready_o,
    output byte_stream_pkg::byte_t m_data_o,
    output logic                   m_valid_o,
    output logic                   rts_o
);

    import byte_stream_pkg::*;

    localparam int unsigned AW         = $clog2(FIFO_DEPTH);
    localparam fifo_level_t DEPTH_LVL  = fifo_level_t'(FIFO_DEPTH);
    localparam fifo_level_t MARGIN_LVL = fifo_level_t'(RTS_MARGIN);

    byte_t       mem [FIFO_DEPTH];
    logic [AW-1:0] wr_ptr;
    logic [AW-1:0] rd_ptr;
    fifo_level_t level;
    fifo_level_t free_cnt;
    logic        wr_en;
    logic        rd_en;

    assign s_ready_o = (level != DEPTH_LVL);
    assign m_valid_o = (level != '0);
    assign wr_en     = s_valid_i && s_ready_o;
    assign rd_en     = m_valid_o && m_ready_i;

    always_ff @(posedge clk_i or negedge arstn_i) begin
        if (!arstn_i) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            level  <= '0;
        end else begin
            if (wr_en) begin
                wr_ptr <= wr_ptr + 1'b1; // Depth is a power of two, wraps itself.
            end
            if (rd_en) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({wr_en, rd_en})
                2'b10:   level <= level + 1'b1;
                2'b01:   level <= level - 1'b1;
                default: level <= level;
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (wr_en) begin
            mem[wr_ptr] <= s_data_i;
        end
    end

    assign m_data_o = mem[rd_ptr];

    // Ask the peer to pause before the last entries fill.
    assign free_cnt = DEPTH_LVL - level;
    assign rts_o    = (free_cnt >= MARGIN_LVL);

endmodule

`default_nettype wire

//--- byte_stream_pkg.sv
// Byte type and FIFO occupancy type for the byte streams.

`default_nettype none

package byte_stream_pkg;

    // One data byte on a stream.
    typedef logic [7:0] byte_t;

    // Occupancy from 0 to 16 entries.
    typedef logic [4:0] fifo_level_t;

endpackage

`default_nettype wire

//--- run_sim.sh
#!/bin/sh
# Builds the UART echo testbench with Verilator, runs it and checks for the pass line.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/1ps --top-module tb_uart_echo \
    -f uart_echo.f -Mdir obj_dir -o tb_uart_echo
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit 1
fi

output=$(./obj_dir/tb_uart_echo)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$output" | grep -qx "all tests passed"; then
    exit 0
fi

echo "Pass line not found in simulation output"
exit 1

//--- tb_uart_echo.sv
// Testbench for the UART echo top level with line driver, line monitor, checks and watchdog.

`default_nettype none

module tb_uart_echo;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int unsigned CLK_FREQ   = 25_000_000;
    localparam int unsigned BAUD_RATE  = 1_562_500;
    localparam int unsigned FIFO_DEPTH = 8;
    localparam int unsigned RTS_MARGIN = 2;
    localparam int          RATIO      = int'(CLK_FREQ / BAUD_RATE);
    localparam int          FRAME      = 10 * RATIO; // Cycles per 8N1 frame.
    localparam int          CLK_PERIOD = 40;
    localparam int          MAX_TESTS  = 32;
    localparam int          MAX_BYTES  = 8;
    localparam logic [31:0] MODE_HOLD  = 32'("hold");
    localparam logic [31:0] MODE_RTS   = 32'("rts");
    localparam              TESTDATA_FILE = "uart_echo_testdata.txt";

    logic clk_i;
    logic arstn_i;
    logic uart_rx_i;
    logic cts_i;
    logic uart_tx_o;
    logic rts_o;

    logic [127:0] test_name   [MAX_TESTS];
    logic [31:0]  test_mode   [MAX_TESTS];
    int           test_glitch [MAX_TESTS];
    int           test_len    [MAX_TESTS];
    logic [7:0]   test_bytes  [MAX_TESTS][MAX_BYTES];
    int           num_tests;
    int           total_bytes;
    logic         loaded;
    logic [7:0]   echo_q[$];
    int           frame_cnt;
    int           error_cnt;
    int           pass_cnt;
    int           fail_cnt;
    int           seed;
    logic [127:0] cur_name;

    initial begin
        clk_i = 1'b0;
        forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
    end

    uart_echo #(
        .CLK_FREQ   (CLK_FREQ),
        .BAUD_RATE  (BAUD_RATE),
        .FIFO_DEPTH (FIFO_DEPTH),
        .RTS_MARGIN (RTS_MARGIN)
    ) u_dut (
        .clk_i     (clk_i),
        .arstn_i   (arstn_i),
        .uart_rx_i (uart_rx_i),
        .cts_i     (cts_i),
        .uart_tx_o (uart_tx_o),
        .rts_o     (rts_o)
    );

    //////////////////////////////
    // Helpers
    //////////////////////////////

    task automatic check_value(input logic [127:0] name, input string what,
                               input logic [31:0] expected, input logic [31:0] actual);
        if (expected !== actual) begin
            $display("Mismatch in %0s, %0s: expected %0h, actual %0h",
                     name, what, expected, actual);
            error_cnt++;
        end
    endtask

    task automatic report_result(input int errors_before);
        if (error_cnt == errors_before) begin
            pass_cnt++;
            $display("PASS %0s", cur_name);
        end else begin
            fail_cnt++;
            $display("FAIL %0s", cur_name);
        end
    endtask

    task automatic load_tests();
        int           fd;
        int           n;
        int           j;
        string        line;
        logic [127:0] name_v;
        logic [31:0]  mode_v;
        int           glitch_v;
        logic [7:0]   b [MAX_BYTES];
        num_tests   = 0;
        total_bytes = 0;
        fd = $fopen(TESTDATA_FILE, "r");
        if (fd == 0) begin
            $display("Could not open the test data file %0s", TESTDATA_FILE);
            error_cnt++;
        end else begin
            while (!$feof(fd) && (num_tests < MAX_TESTS)) begin
                n = $fgets(line, fd);
                if ((n > 0) && (line.getc(0) != "#")) begin
                    name_v = '0;
                    mode_v = '0;
                    n = $sscanf(line, "%s %s %d %h %h %h %h %h %h %h %h", name_v, mode_v,
                                glitch_v, b[0], b[1], b[2], b[3], b[4], b[5], b[6], b[7]);
                    if (n >= 4) begin
                        test_name[num_tests]   = name_v;
                        test_mode[num_tests]   = mode_v;
                        test_glitch[num_tests] = glitch_v;
                        test_len[num_tests]    = n - 3;
                        for (j = 0; j < MAX_BYTES; j++) begin
                            test_bytes[num_tests][j] = b[j];
                        end
                        total_bytes += n - 3;
                        num_tests++;
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    // Start bit, eight data bits LSB first, stop bit.
    task automatic send_frame(input logic [7:0] data);
        logic [9:0] bits;
        int         i;
        bits = {1'b1, data, 1'b0};
        for (i = 0; i < 10; i++) begin
            @(posedge clk_i);
            uart_rx_i <= bits[i];
            repeat (RATIO - 1) @(posedge clk_i);
        end
    endtask

    task automatic send_glitch();
        @(posedge clk_i);
        uart_rx_i <= 1'b0;
        repeat (RATIO / 4) @(posedge clk_i);
        uart_rx_i <= 1'b1;
        repeat (2 * RATIO) @(posedge clk_i);
    endtask

    task automatic run_test(input int idx);
        int   errors_before;
        int   echo_base;
        int   gap;
        int   k;
        int   free_cnt;
        int   rts_exp;
        logic held;
        logic check_rts;
        errors_before = error_cnt;
        echo_base     = echo_q.size();
        cur_name      = test_name[idx];
        check_rts     = (test_mode[idx] == MODE_RTS);
        held          = (test_mode[idx] == MODE_HOLD) || check_rts;
        if (held) begin
            @(posedge clk_i);
            cts_i <= 1'b0;
        end
        if (test_glitch[idx] != 0) begin
            send_glitch();
        end
        for (k = 0; k < test_len[idx]; k++) begin
            send_frame(test_bytes[idx][k]);
            if (check_rts) begin
                @(negedge clk_i);
                free_cnt = int'(FIFO_DEPTH) - (k + 1);
                rts_exp  = (free_cnt >= int'(RTS_MARGIN)) ? 1 : 0;
                check_value(cur_name, "rts after byte", rts_exp, 32'(rts_o));
            end
            gap = {$random(seed)} % 16;
            repeat (gap) @(posedge clk_i);
        end
        if (held) begin
            repeat (2 * FRAME) @(posedge clk_i);
            check_value(cur_name, "echo count while cts low", 0, echo_q.size() - echo_base);
            cts_i <= 1'b1;
        end
        while ((echo_q.size() - echo_base) < test_len[idx]) begin
            @(posedge clk_i);
        end
        repeat (2 * FRAME) @(posedge clk_i); // Quiet window for extra frames.
        check_value(cur_name, "echo count", test_len[idx], echo_q.size() - echo_base);
        for (k = 0; (k < test_len[idx]) && ((echo_base + k) < echo_q.size()); k++) begin
            check_value(cur_name, "echoed byte", 32'(test_bytes[idx][k]),
                        32'(echo_q[echo_base + k]));
        end
        if (check_rts) begin
            @(negedge clk_i);
            check_value(cur_name, "rts after drain", 1, 32'(rts_o));
        end
        report_result(errors_before);
    endtask

    //////////////////////////////
    // Line monitor
    //////////////////////////////

    initial begin : line_monitor
        logic [7:0] data;
        int         i;
        frame_cnt = 0;
        while (arstn_i !== 1'b1) @(posedge clk_i);
        forever begin
            @(negedge uart_tx_o);
            frame_cnt++;
            repeat (RATIO / 2) @(negedge clk_i); // Middle of the start bit.
            for (i = 0; i < 8; i++) begin
                repeat (RATIO) @(negedge clk_i);
                data[i] = uart_tx_o;
            end
            repeat (RATIO) @(negedge clk_i);
            check_value(cur_name, "stop bit", 1, 32'(uart_tx_o));
            echo_q.push_back(data);
        end
    end

    initial begin : watchdog
        longint timeout_ns;
        wait (loaded === 1'b1);
        timeout_ns = longint'(total_bytes) * 10 * RATIO * CLK_PERIOD * 3
                   + longint'(num_tests + 4) * 6 * FRAME * CLK_PERIOD;
        #(timeout_ns);
        $display("timeout waiting for echoed data");
        $display("tests failed");
        $finish;
    end

    //////////////////////////////
    // Test sequence
    //////////////////////////////

    initial begin : main_sequence
        int i;
        int errors_before;
        arstn_i   <= 1'b0;
        uart_rx_i <= 1'b1;
        cts_i     <= 1'b1;
        seed      = 19250;
        error_cnt = 0;
        pass_cnt  = 0;
        fail_cnt  = 0;
        loaded    = 1'b0;
        load_tests();
        loaded = 1'b1;

        cur_name      = "idle_after_reset";
        errors_before = error_cnt;
        repeat (5) @(posedge clk_i);
        @(negedge clk_i);
        check_value(cur_name, "tx line in reset", 1, 32'(uart_tx_o));
        check_value(cur_name, "rts in reset", 1, 32'(rts_o));
        repeat (5) @(posedge clk_i);
        arstn_i <= 1'b1;
        @(negedge clk_i);
        check_value(cur_name, "tx line after reset", 1, 32'(uart_tx_o));
        check_value(cur_name, "rts after reset", 1, 32'(rts_o));
        repeat (2 * FRAME) @(posedge clk_i);
        check_value(cur_name, "frames without input", 0, frame_cnt);
        report_result(errors_before);

        for (i = 0; i < num_tests; i++) begin
            run_test(i);
        end

        $display("Summary: %0d passed, %0d failed", pass_cnt, fail_cnt);
        if ((fail_cnt == 0) && (error_cnt == 0)) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- uart_echo.f
uart_line_pkg.sv
byte_stream_pkg.sv
uart_rx.sv
uart_tx.sv
byte_fifo.sv
uart_echo.sv
tb_uart_echo.sv

//--- uart_echo.sv
// UART echo top level joining receiver, byte FIFO and transmitter.

`default_nettype none

module uart_echo #(
    parameter int unsigned CLK_FREQ   = 25_000_000,
    parameter int unsigned BAUD_RATE  = 115_200,
    parameter int unsigned FIFO_DEPTH = 8,
    parameter int unsigned RTS_MARGIN = 2
) (
    input  logic clk_i,
    input  logic arstn_i,
    input  logic uart_rx_i,
    input  logic cts_i,
    output logic uart_tx_o,
    output logic rts_o
);

    import byte_stream_pkg::*;

    byte_t rx_byte;
    logic  rx_valid;
    logic  rx_ready;
    byte_t tx_byte;
    logic  tx_valid;
    logic  tx_ready;

    //////////////////////////////
    // Receive path
    //////////////////////////////

    uart_rx #(
        .CLK_FREQ  (CLK_FREQ),
        .BAUD_RATE (BAUD_RATE)
    ) u_rx (
        .clk_i     (clk_i),
        .arstn_i   (arstn_i),
        .uart_rx_i (uart_rx_i),
        .m_ready_i (rx_ready),
        .m_data_o  (rx_byte),
        .m_valid_o (rx_valid)
    );

    byte_fifo #(
        .FIFO_DEPTH (FIFO_DEPTH),
        .RTS_MARGIN (RTS_MARGIN)
    ) u_fifo (
        .clk_i     (clk_i),
        .arstn_i   (arstn_i),
        .s_data_i  (rx_byte),
        .s_valid_i (rx_valid),
        .m_ready_i (tx_ready),
        .s_ready_o (rx_ready),
        .m_data_o  (tx_byte),
        .m_valid_o (tx_valid),
        .rts_o     (rts_o)
    );

    //////////////////////////////
    // Echo path
    //////////////////////////////

    uart_tx #(
        .CLK_FREQ  (CLK_FREQ),
        .BAUD_RATE (BAUD_RATE)
    ) u_tx (
        .clk_i     (clk_i),
        .arstn_i   (arstn_i),
        .s_data_i  (tx_byte),
        .s_valid_i (tx_valid),
        .cts_i     (cts_i),
        .s_ready_o (tx_ready),
        .uart_tx_o (uart_tx_o)
    );

endmodule

`default_nettype wire

//--- uart_echo_testdata.txt
# name mode glitch bytes(hex, up to 8); the bytes are sent and must echo back unchanged
# mode on keeps cts high, hold keeps cts low until all are sent, rts also checks rts per byte
single_55 on 0 55
single_00 on 0 00
single_ff on 0 ff
single_a5 on 0 a5
single_01 on 0 01
single_80 on 0 80
single_c3 on 0 c3
pair_3c_c3 on 0 3c c3
burst_four on 0 de ad be ef
burst_eight on 0 00 11 22 33 44 55 66 77
walk_ones on 0 01 02 04 08 10 20 40 80
walk_zeros on 0 fe fd fb f7 ef df bf 7f
ascii_hello on 0 48 65 6c 6c 6f
glitch_then_5a on 1 5a
glitch_then_pair on 1 0f f0
glitch_then_ff on 1 ff
cts_hold_three hold 0 12 34 56
cts_hold_one hold 0 9c
cts_hold_five hold 0 a1 b2 c3 d4 e5
rts_fill_eight rts 0 10 20 30 40 50 60 70 80
rts_fill_seven rts 0 c0 c1 c2 c3 c4 c5 c6
mixed_after on 0 aa 55

//--- uart_line_pkg.sv
// Serial line timing types and the receiver and transmitter state enums.

`default_nettype none

package uart_line_pkg;

    // Clock cycles within one bit time.
    typedef logic [15:0] baud_cnt_t;

    // Data bit index within a frame.
    typedef logic [2:0] bit_cnt_t;

    typedef enum logic [2:0] {
        RX_IDLE  = 3'd0,
        RX_START = 3'd1,
        RX_DATA  = 3'd2,
        RX_STOP  = 3'd3,
        RX_WAIT  = 3'd4
    } rx_state_t;

    typedef enum logic [1:0] {
        TX_IDLE  = 2'd0,
        TX_START = 2'd1,
        TX_DATA  = 2'd2,
        TX_STOP  = 2'd3
    } tx_state_t;

endpackage

`default_nettype wire

//--- uart_rx.sv
// UART receiver with mid-bit start check and a valid/ready byte output.

`default_nettype none

module uart_rx #(
    parameter int unsigned CLK_FREQ  = 25_000_000,
    parameter int unsigned BAUD_RATE = 115_200
) (
    input  logic                   clk_i,
    input  logic                   arstn_i,
    input  logic                   uart_rx_i,
    input  logic                   m_ready_i,
    output byte_stream_pkg::byte_t m_data_o,
    output logic                   m_valid_o
);

    import uart_line_pkg::*;
    import byte_stream_pkg::*;

    localparam int unsigned RATIO     = CLK_FREQ / BAUD_RATE;
    localparam baud_cnt_t   BIT_LAST  = baud_cnt_t'(RATIO - 1);
    localparam baud_cnt_t   HALF_LAST = baud_cnt_t'(RATIO / 2 - 1);

    rx_state_t state;
    baud_cnt_t baud_cnt;
    bit_cnt_t  bit_cnt;
    byte_t     shift_q;
    logic      sent_q;
    logic      half_tick;
    logic      bit_tick;

    assign half_tick = (state == RX_START) && (baud_cnt == HALF_LAST);
    assign bit_tick  = (baud_cnt == BIT_LAST);

    //////////////////////////////
    // Frame state machine
    //////////////////////////////

    always_ff @(posedge clk_i or negedge arstn_i) begin
        if (!arstn_i) begin
            state    <= RX_IDLE;
            baud_cnt <= '0;
            bit_cnt  <= '0;
            sent_q   <= 1'b0;
        end else begin
            case (state)
                RX_IDLE: begin
                    baud_cnt <= '0;
                    bit_cnt  <= '0;
                    if (!uart_rx_i) begin
                        state <= RX_START;
                    end
                end
                RX_START: begin
                    if (half_tick) begin
                        baud_cnt <= '0;
                        state    <= uart_rx_i ? RX_IDLE : RX_DATA; // High at mid-bit is a glitch.
                    end else begin
                        baud_cnt <= baud_cnt + 1'b1;
                    end
                end
                RX_DATA: begin
                    if (bit_tick) begin
                        baud_cnt <= '0;
                        bit_cnt  <= bit_cnt + 1'b1;
                        if (bit_cnt == '1) begin
                            state <= RX_STOP;
                        end
                    end else begin
                        baud_cnt <= baud_cnt + 1'b1;
                    end
                end
                RX_STOP: begin
                    if (m_valid_o && m_ready_i) begin
                        sent_q <= 1'b1; // One delivery per byte.
                    end
                    if (bit_tick) begin
                        baud_cnt <= '0;
                        state    <= RX_WAIT;
                    end else begin
                        baud_cnt <= baud_cnt + 1'b1;
                    end
                end
                RX_WAIT: begin
                    sent_q <= 1'b0;
                    state  <= RX_IDLE;
                end
                default: begin
                    state <= RX_IDLE;
                end
            endcase
        end
    end

    //////////////////////////////
    // Data shift register
    //////////////////////////////

    // Samples land at mid-bit, LSB first.
    always_ff @(posedge clk_i) begin
        if ((state == RX_DATA) && bit_tick) begin
            shift_q <= {uart_rx_i, shift_q[7:1]};
        end
    end

    assign m_data_o  = shift_q;
    assign m_valid_o = (state == RX_STOP) && !sent_q;

endmodule

`default_nettype wire

//--- uart_tx.sv
// UART transmitter taking bytes by valid/ready and sending 8N1 frames.

`default_nettype none

module uart_tx #(
    parameter int unsigned CLK_FREQ  = 25_000_000,
    parameter int unsigned BAUD_RATE = 115_200
) (
    input  logic                   clk_i,
    input  logic                   arstn_i,
    input  byte_stream_pkg::byte_t s_data_i,
    input  logic                   s_valid_i,
    input  logic                   cts_i,
    output logic                   s_ready_o,
    output logic                   uart_tx_o
);

    import uart_line_pkg::*;
    import byte_stream_pkg::*;

    localparam int unsigned RATIO    = CLK_FREQ / BAUD_RATE;
    localparam baud_cnt_t   BIT_LAST = baud_cnt_t'(RATIO - 1);

    tx_state_t state;
    baud_cnt_t baud_cnt;
    bit_cnt_t  bit_cnt;
    byte_t     shift_q;
    logic      line_q;
    logic      accept;
    logic      bit_tick;

    assign s_ready_o = (state == TX_IDLE) && cts_i; // Peer gates new frames only.
    assign accept    = s_valid_i && s_ready_o;
    assign bit_tick  = (baud_cnt == BIT_LAST);

    always_ff @(posedge clk_i or negedge arstn_i) begin
        if (!arstn_i) begin
            state    <= TX_IDLE;
            baud_cnt <= '0;
            bit_cnt  <= '0;
            line_q   <= 1'b1;
        end else begin
            case (state)
                TX_IDLE: begin
                    baud_cnt <= '0;
                    bit_cnt  <= '0;
                    if (accept) begin
                        line_q <= 1'b0; // Start bit.
                        state  <= TX_START;
                    end
                end
                TX_START: begin
                    if (bit_tick) begin
                        baud_cnt <= '0;
                        line_q   <= shift_q[0];
                        state    <= TX_DATA;
                    end else begin
                        baud_cnt <= baud_cnt + 1'b1;
                    end
                end
                TX_DATA: begin
                    if (bit_tick) begin
                        baud_cnt <= '0;
                        bit_cnt  <= bit_cnt + 1'b1;
                        if (bit_cnt == '1) begin
                            line_q <= 1'b1; // Stop bit.
                            state  <= TX_STOP;
                        end else begin
                            line_q <= shift_q[1];
                        end
                    end else begin
                        baud_cnt <= baud_cnt + 1'b1;
                    end
                end
                TX_STOP: begin
                    if (bit_tick) begin
                        baud_cnt <= '0;
                        state    <= TX_IDLE;
                    end else begin
                        baud_cnt <= baud_cnt + 1'b1;
                    end
                end
                default: begin
                    state <= TX_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (accept) begin
            shift_q <= s_data_i;
        end else if ((state == TX_DATA) && bit_tick) begin
            shift_q <= shift_q >> 1;
        end
    end

    assign uart_tx_o = line_q;

endmodule

`default_nettype wire
